// File: all.f
logic/rd_dwc_pkg.sv
logic/rd_beat_tracker.sv
logic/rd_resp_merge.sv
logic/rd_master_stage.sv
logic/rd_width_conv_down.sv
tests/rd_dwc_assertions.sv
tests/tb_rd_width_conv_down.sv

// File: logic/rd_beat_tracker.sv
`timescale 1ns/1ps

module rd_beat_tracker (
   input  logic                          ACLK,
   input  logic                          sysReset,
   input  rd_dwc_pkg::rd_cmd_t           cmd,
   input  logic                          slv_take,
   input  logic                          slv_last,
   output logic [rd_dwc_pkg::OFFS_W-1:0] lane_offs,
   output logic                          word_done
);

   logic                          first_beat;
   logic [rd_dwc_pkg::OFFS_W-1:0] offs_q;
   logic [rd_dwc_pkg::OFFS_W-1:0] slv_bytes;
   logic [rd_dwc_pkg::OFFS_W-1:0] start_aligned;
   logic [rd_dwc_pkg::OFFS_W-1:0] end_offs;
   logic [rd_dwc_pkg::OFFS_W:0]   window;
   logic [rd_dwc_pkg::OFFS_W-1:0] win_mask;
   logic                          window_full;

   ///////////////////////////////////////////////////////////////////////
   // Byte offset of the current beat
   ///////////////////////////////////////////////////////////////////////

   assign slv_bytes     = rd_dwc_pkg::slv_bytes_of(cmd.size);
   assign start_aligned = cmd.start_offs & ~(slv_bytes - 1'b1);

   // First beat of a transaction starts from the command address
   assign lane_offs = first_beat ? start_aligned : offs_q;

   ///////////////////////////////////////////////////////////////////////
   // Window fill detection
   ///////////////////////////////////////////////////////////////////////

   // Master-size window, up to the full 16-byte word
   assign window   = (rd_dwc_pkg::OFFS_W + 1)'(1) << cmd.size;
   assign win_mask = rd_dwc_pkg::OFFS_W'(window - 1'b1);

   // Last byte written by this beat; offsets are aligned so no wrap here
   assign end_offs = lane_offs + slv_bytes - 1'b1;

   assign window_full = (end_offs & win_mask) == win_mask;

   // A final beat of the burst flushes a partly filled word
   assign word_done = window_full | (slv_last & cmd.last_tx);

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         first_beat <= 1'b1;
         offs_q     <= '0;
      end
      else if (slv_take)
      begin
         first_beat <= slv_last;
         // Wraps modulo MST_BYTES through the offset width
         offs_q     <= lane_offs + slv_bytes;
      end
   end

endmodule

// File: logic/rd_dwc_pkg.sv
package rd_dwc_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Bus widths and sizes
   ///////////////////////////////////////////////////////////////////////

   localparam int SLV_DATA_W   = 32;
   localparam int MST_DATA_W   = 128;
   localparam int SLV_BYTES    = SLV_DATA_W / 8;
   localparam int MST_BYTES    = MST_DATA_W / 8;
   localparam int SLV_SIZE_MAX = 2;
   localparam int OFFS_W       = 4;
   localparam int SIZE_W       = 3;
   localparam int ID_W         = 4;
   localparam int RESP_W       = 2;

   // One entry of the read command queue
   typedef struct packed {
      logic [OFFS_W-1:0] start_offs;
      logic [SIZE_W-1:0] size;
      logic              last_tx;
   } rd_cmd_t;

   // Narrow R channel beat
   typedef struct packed {
      logic [SLV_DATA_W-1:0] data;
      logic [ID_W-1:0]       id;
      logic [RESP_W-1:0]     resp;
      logic                  last;
   } slv_beat_t;

   // Wide R channel beat
   typedef struct packed {
      logic [MST_DATA_W-1:0] data;
      logic [ID_W-1:0]       id;
      logic [RESP_W-1:0]     resp;
      logic                  last;
   } mst_beat_t;

   // Bytes moved per slave beat, the transfer size capped at the slave width
   function automatic logic [OFFS_W-1:0] slv_bytes_of(input logic [SIZE_W-1:0] size);
      logic [SIZE_W-1:0] slv_size;
      slv_size = (size > SIZE_W'(SLV_SIZE_MAX)) ? SIZE_W'(SLV_SIZE_MAX) : size;
      return OFFS_W'(1) << slv_size;
   endfunction

endpackage

// File: logic/rd_master_stage.sv
`timescale 1ns/1ps

module rd_master_stage (
   input  logic                          ACLK,
   input  logic                          sysReset,
   input  logic                          cmd_empty,
   input  rd_dwc_pkg::rd_cmd_t           cmd,
   input  rd_dwc_pkg::slv_beat_t         slv_r,
   input  logic                          slv_rvalid,
   input  logic                          mst_rready,
   input  logic [rd_dwc_pkg::OFFS_W-1:0] lane_offs,
   input  logic                          word_done,
   input  logic [rd_dwc_pkg::RESP_W-1:0] resp_next,
   output logic                          slv_rready,
   output logic                          slv_take,
   output logic                          cmd_pop,
   output rd_dwc_pkg::mst_beat_t         mst_r,
   output logic                          mst_rvalid
);

   logic                             mst_stall;
   logic [rd_dwc_pkg::OFFS_W-1:0]    slv_bytes;
   logic [rd_dwc_pkg::MST_BYTES-1:0] lane_en;

   ///////////////////////////////////////////////////////////////////////
   // Handshake and queue control
   ///////////////////////////////////////////////////////////////////////

   // Pending master beat not yet accepted
   assign mst_stall = mst_rvalid & ~mst_rready;

   assign slv_rready = ~cmd_empty & ~mst_stall;
   assign slv_take   = slv_rready & slv_rvalid;

   // Command retires with the last slave beat of its transaction
   assign cmd_pop = slv_take & slv_r.last;

   ///////////////////////////////////////////////////////////////////////
   // Byte lanes written by the current beat
   ///////////////////////////////////////////////////////////////////////

   assign slv_bytes = rd_dwc_pkg::slv_bytes_of(cmd.size);

   assign lane_en = rd_dwc_pkg::MST_BYTES'(
                       ((rd_dwc_pkg::MST_BYTES)'(1) << slv_bytes) - 1'b1) << lane_offs;

   ///////////////////////////////////////////////////////////////////////
   // Wide accumulator and output beat
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         mst_r      <= '0;
         mst_rvalid <= 1'b0;
      end
      else
      begin
         if (slv_take)
         begin
            // Master byte b takes slave byte b mod SLV_BYTES
            for (int b = 0; b < rd_dwc_pkg::MST_BYTES; b++)
            begin
               if (lane_en[b])
               begin
                  mst_r.data[b*8 +: 8] <= slv_r.data[(b % rd_dwc_pkg::SLV_BYTES)*8 +: 8];
               end
            end
            mst_r.id <= slv_r.id;
         end

         if (slv_take && word_done)
         begin
            mst_rvalid <= 1'b1;
            mst_r.resp <= resp_next;
            mst_r.last <= slv_r.last & cmd.last_tx;
         end
         else if (mst_rready)
         begin
            mst_rvalid <= 1'b0;
         end
      end
   end

endmodule

// File: logic/rd_resp_merge.sv
`timescale 1ns/1ps

module rd_resp_merge (
   input  logic                          ACLK,
   input  logic                          sysReset,
   input  logic                          slv_take,
   input  logic [rd_dwc_pkg::RESP_W-1:0] slv_resp,
   input  logic                          word_done,
   output logic [rd_dwc_pkg::RESP_W-1:0] resp_next
);

   // Worst response seen since the last completed word
   logic [rd_dwc_pkg::RESP_W-1:0] resp_max;

   // Current beat counts too, it may be the one that closes the word
   assign resp_next = (slv_resp > resp_max) ? slv_resp : resp_max;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         resp_max <= '0;
      end
      else if (slv_take)
      begin
         if (word_done)
         begin
            // Merged value leaves with the master beat
            resp_max <= '0;
         end
         else
         begin
            resp_max <= resp_next;
         end
      end
   end

endmodule

// File: logic/rd_width_conv_down.sv
`timescale 1ns/1ps

module rd_width_conv_down (
   input  logic                  ACLK,
   input  logic                  sysReset,
   input  rd_dwc_pkg::rd_cmd_t   cmd,
   input  logic                  cmd_empty,
   output logic                  cmd_pop,
   input  rd_dwc_pkg::slv_beat_t slv_r,
   input  logic                  slv_rvalid,
   output logic                  slv_rready,
   output rd_dwc_pkg::mst_beat_t mst_r,
   output logic                  mst_rvalid,
   input  logic                  mst_rready
);

   logic                          slv_take;
   logic [rd_dwc_pkg::OFFS_W-1:0] lane_offs;
   logic                          word_done;
   logic [rd_dwc_pkg::RESP_W-1:0] resp_next;

   ///////////////////////////////////////////////////////////////////////
   // Beat position and word completion
   ///////////////////////////////////////////////////////////////////////

   rd_beat_tracker u_tracker (
      .ACLK      (ACLK),
      .sysReset  (sysReset),
      .cmd       (cmd),
      .slv_take  (slv_take),
      .slv_last  (slv_r.last),
      .lane_offs (lane_offs),
      .word_done (word_done)
   );

   // Worst response across one master beat
   rd_resp_merge u_resp_merge (
      .ACLK      (ACLK),
      .sysReset  (sysReset),
      .slv_take  (slv_take),
      .slv_resp  (slv_r.resp),
      .word_done (word_done),
      .resp_next (resp_next)
   );

   ///////////////////////////////////////////////////////////////////////
   // Data packing and master R channel
   ///////////////////////////////////////////////////////////////////////

   rd_master_stage u_master_stage (
      .ACLK       (ACLK),
      .sysReset   (sysReset),
      .cmd_empty  (cmd_empty),
      .cmd        (cmd),
      .slv_r      (slv_r),
      .slv_rvalid (slv_rvalid),
      .mst_rready (mst_rready),
      .lane_offs  (lane_offs),
      .word_done  (word_done),
      .resp_next  (resp_next),
      .slv_rready (slv_rready),
      .slv_take   (slv_take),
      .cmd_pop    (cmd_pop),
      .mst_r      (mst_r),
      .mst_rvalid (mst_rvalid)
   );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the read width converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rd_width_conv_down --Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_rd_width_conv_down" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
   exit 1
fi
exit 0

// File: tests/rd_dwc_assertions.sv
`timescale 1ns/1ps

module rd_dwc_assertions (
   input logic                  ACLK,
   input logic                  sysReset,
   input logic                  cmd_empty,
   input logic                  cmd_pop,
   input rd_dwc_pkg::slv_beat_t slv_r,
   input logic                  slv_rvalid,
   input logic                  slv_rready,
   input rd_dwc_pkg::mst_beat_t mst_r,
   input logic                  mst_rvalid,
   input logic                  mst_rready
);

   // Master beat holds until it is accepted
   mst_stable_a : assert property (@(posedge ACLK) disable iff (!sysReset)
      (mst_rvalid && !mst_rready) |=> (mst_rvalid && $stable(mst_r)))
      else $error("master R beat changed while stalled");

   // No slave beat is taken without a command
   no_cmd_stall_a : assert property (@(posedge ACLK) disable iff (!sysReset)
      cmd_empty |-> !slv_rready)
      else $error("slave side ready with an empty command queue");

   // Command retires only with an accepted last beat
   pop_on_last_a : assert property (@(posedge ACLK) disable iff (!sysReset)
      cmd_pop |-> (slv_rvalid && slv_rready && slv_r.last))
      else $error("command popped without an accepted last slave beat");

endmodule

bind rd_width_conv_down rd_dwc_assertions u_assertions (
   .ACLK       (ACLK),
   .sysReset   (sysReset),
   .cmd_empty  (cmd_empty),
   .cmd_pop    (cmd_pop),
   .slv_r      (slv_r),
   .slv_rvalid (slv_rvalid),
   .slv_rready (slv_rready),
   .mst_r      (mst_r),
   .mst_rvalid (mst_rvalid),
   .mst_rready (mst_rready)
);

// File: tests/tb_rd_width_conv_down.sv
`timescale 1ns/1ps

module tb_rd_width_conv_down;

   localparam int WAIT_LIMIT = 200;

   logic                  ACLK;
   logic                  sysReset;
   rd_dwc_pkg::rd_cmd_t   cmd;
   logic                  cmd_empty;
   logic                  cmd_pop;
   rd_dwc_pkg::slv_beat_t slv_r;
   logic                  slv_rvalid;
   logic                  slv_rready;
   rd_dwc_pkg::mst_beat_t mst_r;
   logic                  mst_rvalid;
   logic                  mst_rready;

   logic [31:0] lfsr;
   // Ready pattern runs on its own LFSR state
   logic [31:0] rdy_lfsr;
   logic        rready_random;
   int          errors;
   int          checks;
   int          timeouts;
   int          pops;

   // Reference byte model of the wide word
   logic [7:0]                    ref_bytes [rd_dwc_pkg::MST_BYTES];
   int                            ref_offs;
   logic                          ref_first;
   logic [rd_dwc_pkg::RESP_W-1:0] ref_resp;
   rd_dwc_pkg::mst_beat_t         exp_q [$];
   rd_dwc_pkg::mst_beat_t         got_q [$];

   rd_width_conv_down DUT (
      .ACLK       (ACLK),
      .sysReset   (sysReset),
      .cmd        (cmd),
      .cmd_empty  (cmd_empty),
      .cmd_pop    (cmd_pop),
      .slv_r      (slv_r),
      .slv_rvalid (slv_rvalid),
      .slv_rready (slv_rready),
      .mst_r      (mst_r),
      .mst_rvalid (mst_rvalid),
      .mst_rready (mst_rready)
   );

   always #5 ACLK = ~ACLK;

   ///////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ///////////////////////////////////////////////////////////////////////

   // Fibonacci taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic rd_dwc_pkg::rd_cmd_t make_cmd(input int offs, input int size, input logic lt);
      rd_dwc_pkg::rd_cmd_t c;
      c.start_offs = rd_dwc_pkg::OFFS_W'(offs);
      c.size       = rd_dwc_pkg::SIZE_W'(size);
      c.last_tx    = lt;
      return c;
   endfunction

   task automatic check_int(input string what, input int got, input int exp);
      checks++;
      assert (got == exp) else
      begin
         errors++;
         $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // One accepted slave beat; byte at address a rides on slave lane a mod 4
   task automatic model_beat(input rd_dwc_pkg::rd_cmd_t c, input rd_dwc_pkg::slv_beat_t b);
      int                    sz;
      int                    nbytes;
      int                    offs;
      rd_dwc_pkg::mst_beat_t e;
      sz     = (int'(c.size) > rd_dwc_pkg::SLV_SIZE_MAX) ? rd_dwc_pkg::SLV_SIZE_MAX : int'(c.size);
      nbytes = 1 << sz;
      offs   = ref_first ? (int'(c.start_offs) / nbytes) * nbytes : ref_offs;
      for (int i = 0; i < nbytes; i++)
      begin
         ref_bytes[offs + i] = b.data[((offs + i) % rd_dwc_pkg::SLV_BYTES) * 8 +: 8];
      end
      if (b.resp > ref_resp)
      begin
         ref_resp = b.resp;
      end
      if ((offs + nbytes) % (1 << c.size) == 0 || (b.last && c.last_tx))
      begin
         for (int k = 0; k < rd_dwc_pkg::MST_BYTES; k++)
         begin
            e.data[k*8 +: 8] = ref_bytes[k];
         end
         e.id     = b.id;
         e.resp   = ref_resp;
         e.last   = b.last & c.last_tx;
         ref_resp = '0;
         exp_q.push_back(e);
      end
      ref_offs  = (offs + nbytes) % rd_dwc_pkg::MST_BYTES;
      ref_first = b.last;
   endtask

   task automatic send_beat(input rd_dwc_pkg::rd_cmd_t c, input rd_dwc_pkg::slv_beat_t b);
      int n;
      n = 0;
      @(negedge ACLK);
      slv_r      = b;
      slv_rvalid = 1'b1;
      @(posedge ACLK);
      while (!slv_rready && n < WAIT_LIMIT)
      begin
         n++;
         @(posedge ACLK);
      end
      if (!slv_rready)
      begin
         timeouts++;
         $display("timeout at %0t, slave beat was never accepted", $time);
      end
      else
      begin
         check_int("cmd_pop on accepted beat", cmd_pop, b.last);
         model_beat(c, b);
      end
   endtask

   // Slave transaction under one command
   // Beat bad_idx carries SLVERR
   task automatic send_tx(input rd_dwc_pkg::rd_cmd_t c, input int nbeats, input int bad_idx);
      rd_dwc_pkg::slv_beat_t b;
      logic [31:0]           r;
      take_bits(rd_dwc_pkg::ID_W, r);
      b.id = rd_dwc_pkg::ID_W'(r);
      @(negedge ACLK);
      cmd       = c;
      cmd_empty = 1'b0;
      for (int i = 0; i < nbeats && timeouts == 0; i++)
      begin
         take_bits(32, r);
         b.data = r;
         b.resp = (i == bad_idx) ? 2'd2 : 2'd0;
         b.last = (i == nbeats - 1);
         send_beat(c, b);
      end
      @(negedge ACLK);
      slv_rvalid = 1'b0;
      cmd_empty  = 1'b1;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || mst_rvalid) && n < WAIT_LIMIT)
      begin
         n++;
         @(posedge ACLK);
      end
      if (exp_q.size() != 0 || mst_rvalid)
      begin
         timeouts++;
         $display("timeout at %0t, master beats did not drain", $time);
      end
      @(negedge ACLK);
   endtask

   always @(negedge ACLK)
   begin
      if (rready_random)
      begin
         rdy_lfsr    = lfsr_step(rdy_lfsr);
         mst_rready <= rdy_lfsr[0];
      end
      else
      begin
         mst_rready <= 1'b1;
      end
   end

   // Master side monitor
   always @(posedge ACLK)
   begin
      rd_dwc_pkg::mst_beat_t e;
      if (sysReset)
      begin
         if (cmd_pop)
         begin
            pops++;
         end
         if (mst_rvalid && !mst_rready)
         begin
            checks++;
            assert (!slv_rready) else
            begin
               errors++;
               $display("slave side was ready at %0t while a master beat was pending", $time);
            end
         end
         if (mst_rvalid && mst_rready)
         begin
            got_q.push_back(mst_r);
            checks++;
            assert (exp_q.size() > 0) else
            begin
               errors++;
               $display("master beat at %0t arrived when none was expected", $time);
            end
            if (exp_q.size() > 0)
            begin
               e = exp_q.pop_front();
               assert (mst_r == e) else
               begin
                  errors++;
                  $display("mismatch at %0t: master beat %h, expected %h", $time, mst_r, e);
               end
            end
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Tests
   ///////////////////////////////////////////////////////////////////////

   task automatic full_width_test();
      got_q.delete();
      send_tx(make_cmd(0, 4, 1'b1), 8, -1);
      wait_drain();
      check_int("full width master beats", got_q.size(), 2);
      if (got_q.size() == 2)
      begin
         check_int("first beat last", got_q[0].last, 0);
         check_int("second beat last", got_q[1].last, 1);
      end
   endtask

   task automatic narrow_test();
      got_q.delete();
      send_tx(make_cmd(6, 1, 1'b1), 4, -1);
      wait_drain();
      check_int("narrow master beats", got_q.size(), 4);
   endtask

   task automatic resp_merge_test();
      got_q.delete();
      send_tx(make_cmd(0, 4, 1'b1), 8, 2);
      wait_drain();
      check_int("merge master beats", got_q.size(), 2);
      if (got_q.size() == 2)
      begin
         check_int("merged resp", got_q[0].resp, 2);
         check_int("following resp", got_q[1].resp, 0);
      end
   endtask

   task automatic backpressure_test();
      got_q.delete();
      rready_random = 1'b1;
      send_tx(make_cmd(4, 3, 1'b1), 8, -1);
      wait_drain();
      rready_random = 1'b0;
      check_int("stalled master beats", got_q.size(), 5);
   endtask

   task automatic split_cmd_test();
      int pops_start;
      pops_start = pops;
      got_q.delete();
      send_tx(make_cmd(0, 4, 1'b0), 2, -1);
      wait_drain();
      check_int("pops after first command", pops - pops_start, 1);
      check_int("master beats after first command", got_q.size(), 0);
      // Empty queue holds off the slave side
      slv_rvalid = 1'b1;
      repeat (3)
      begin
         @(posedge ACLK);
         check_int("slv_rready with empty queue", slv_rready, 0);
      end
      @(negedge ACLK);
      slv_rvalid = 1'b0;
      send_tx(make_cmd(8, 4, 1'b1), 2, -1);
      wait_drain();
      check_int("pops after second command", pops - pops_start, 2);
      check_int("master beats after second command", got_q.size(), 1);
      if (got_q.size() == 1)
      begin
         check_int("split burst last", got_q[0].last, 1);
      end
   endtask

   initial
   begin
      ACLK          = 1'b0;
      sysReset      = 1'b0;
      cmd           = '0;
      cmd_empty     = 1'b1;
      slv_r         = '0;
      slv_rvalid    = 1'b0;
      mst_rready    = 1'b0;
      lfsr          = 32'h2003;
      rdy_lfsr      = 32'h2003;
      rready_random = 1'b0;
      errors        = 0;
      checks        = 0;
      timeouts      = 0;
      pops          = 0;
      ref_offs      = 0;
      ref_first     = 1'b1;
      ref_resp      = '0;
      for (int k = 0; k < rd_dwc_pkg::MST_BYTES; k++)
      begin
         ref_bytes[k] = 8'h00;
      end
      repeat (2) @(posedge ACLK);
      @(negedge ACLK);
      check_int("mst_rvalid in reset", mst_rvalid, 0);
      check_int("mst_r last in reset", mst_r.last, 0);
      check_int("nonzero mst_r data in reset", (mst_r.data != '0), 0);
      sysReset = 1'b1;
      full_width_test();
      if (timeouts == 0) narrow_test();
      if (timeouts == 0) resp_merge_test();
      if (timeouts == 0) backpressure_test();
      if (timeouts == 0) split_cmd_test();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
